//--- bench/aluPipeTb.sv
`include "coreCfg.svh"

module aluPipeTb
    import coreTypesPkg::*, isaPkg::*;
();

    localparam int immBits = 19;               // I-layout immediate field

    // One expected output, in issue order
    typedef struct packed {
        logic                      illegal;
        logic [`OPCODE_WIDTH-1:0]  code;
        data_t                     data;
        regIndex_t                 rd;
        logic [31:0]               due;        // Moving edge on which it is sampled
    } expect_t;

    logic                   clk;
    logic                   reset;
    logic                   hold;
    logic                   issue;
    logic [`DATA_WIDTH-1:0] instrWord;
    pc_t                    pc;
    logic                   resultValid;
    data_t                  resultData;
    regIndex_t              resultRd;
    logic                   illegalOp;

    data_t       mirror [`REG_COUNT];          // Register file as seen at issue time
    expect_t     expQ [$];
    integer      seed;
    int          errorCount;
    int          checkCount;
    int          issuedCount;
    int          cycleCount;
    logic [31:0] movingEdges;                  // Edges with hold low, after reset
    pc_t         pcNext;

    aluPipe DUT (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .issue       (issue),
        .instrWord   (instrWord),
        .pc          (pc),
        .resultValid (resultValid),
        .resultData  (resultData),
        .resultRd    (resultRd),
        .illegalOp   (illegalOp)
    );

    always #50 clk = ~clk;

    // Expected value straight from the ISA rules
    function automatic data_t refResult(opcode_e op, data_t a, data_t b, data_t imm, pc_t pcVal);
        data_t operand;
        case (op)
            ADDI, MULI, DIVI, SLLI: operand = imm;
            default:                operand = b;
        endcase
        case (op)
            ADD, ADDI: return a + operand;
            SUB:       return a - operand;
            MUL, MULI: return a * operand;
            DIV, DIVI: return (operand == 32'd0) ? 32'hFFFF_FFFF : a / operand;
            ABS:       return a & 32'h7FFF_FFFF;
            SLT:       return (a < operand) ? 32'd1 : 32'd0;
            SGT:       return (a > operand) ? 32'd1 : 32'd0;
            SEQ:       return (a == operand) ? 32'd1 : 32'd0;
            SNEZ:      return (a != 32'd0) ? 32'd1 : 32'd0;
            MIN:       return (a < operand) ? a : operand;
            SLL, SLLI: return a << operand[4:0];
            BEQZ:      return (a == 32'd0) ? 32'd1 : 32'd0;
            JAL:       return {16'd0, pcVal} + imm;    // Wraps at 2^32
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] rWord(opcode_e op, regIndex_t rd, regIndex_t rs1,
                                          regIndex_t rs2);
        return {op, rd, rs1, rs2, 15'h0};
    endfunction

    function automatic logic [31:0] iWord(opcode_e op, regIndex_t rd, regIndex_t rs1, int imm);
        logic [31:0] immAll;
        immAll = imm;
        return {op, rd, rs1, immAll[immBits-1:0]};   // Truncated to the field
    endfunction

    // Unknown opcode, other bits arbitrary
    function automatic logic [31:0] badWord(logic [`OPCODE_WIDTH-1:0] code, regIndex_t rd);
        return {code, rd, 4'd1, 19'h5A5A5};
    endfunction

    // Work out what the word must produce and update the mirror
    task automatic recordIssue(input logic [31:0] word, input pc_t pcVal);
        expect_t   e;
        regIndex_t rs1;
        regIndex_t rs2;
        data_t     imm;
        e.code    = word[31:27];
        e.rd      = word[26:23];
        rs1       = word[22:19];
        rs2       = word[18:15];
        imm       = {{(32 - immBits){word[immBits-1]}}, word[immBits-1:0]};
        e.illegal = (e.code > 5'd16);
        e.data    = '0;
        e.due     = movingEdges + 3;           // Fixed 3-edge latency
        if (!e.illegal) begin
            e.data = refResult(opcode_e'(e.code), mirror[rs1], mirror[rs2], imm, pcVal);
            mirror[e.rd] = e.data;
        end
        expQ.push_back(e);
        issuedCount++;
    endtask

    task automatic issueAt(input logic [31:0] word, input pc_t pcVal);
        @(posedge clk);
        #5;
        hold      = 1'b0;
        issue     = 1'b1;
        instrWord = word;
        pc        = pcVal;
        recordIssue(word, pcVal);
    endtask

    task automatic issueNext(input logic [31:0] word);
        issueAt(word, pcNext);
        pcNext += 16'd4;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #5;
        hold  = 1'b0;
        issue = 1'b0;
    endtask

    // Until every expected output has been seen
    task automatic drain();
        idleCycle();
        while (expQ.size() != 0) begin
            idleCycle();
        end
    endtask

    // Mixed stream, hold pulses and bubbles
    task automatic randomStream(input int count);
        int          issued;
        logic [31:0] r;
        logic [31:0] word;
        issued = 0;
        while (issued < count) begin
            @(posedge clk);
            #5;
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                hold      = 1'b1;
                issue     = r[2];              // Ignored while frozen
                instrWord = $random(seed);
            end else if (r[3:0] == 4'b0101) begin
                hold  = 1'b0;
                issue = 1'b0;                  // Bubble
            end else begin
                word        = $random(seed);
                word[31:27] = r[15:8] % 21;    // Codes 17 to 20 illegal
                hold        = 1'b0;
                issue       = 1'b1;
                instrWord   = word;
                pc          = pcNext;
                recordIssue(word, pcNext);
                pcNext += 16'd4;
                issued++;
            end
        end
    endtask

    task automatic checkResult(input data_t expData, input regIndex_t expRd);
        checkCount++;
        if (!resultValid || illegalOp) begin
            errorCount++;
            $display("FAIL %0t: expected result for r%0d, got illegalOp", $time, expRd);
        end else if (resultData !== expData || resultRd !== expRd) begin
            errorCount++;
            $display("FAIL %0t: r%0d = %h, expected r%0d = %h", $time, resultRd, resultData,
                     expRd, expData);
        end
    endtask

    task automatic checkIllegal(input logic [`OPCODE_WIDTH-1:0] code);
        checkCount++;
        if (!illegalOp || resultValid) begin
            errorCount++;
            $display("FAIL %0t: opcode %0d should raise illegalOp, got a result", $time, code);
        end
    endtask

    // Compare on every edge that moves the pipeline
    always @(posedge clk) begin : monitor
        expect_t head;
        if (!reset && !hold) begin
            if ((resultValid || illegalOp) && expQ.size() == 0) begin
                errorCount++;
                $display("Unexpected output pulse at time %0t with nothing outstanding", $time);
            end else if (resultValid || illegalOp) begin
                head = expQ.pop_front();
                if (head.due != movingEdges) begin
                    errorCount++;
                    $display("Output at time %0t came on moving edge %0d instead of %0d",
                             $time, movingEdges, head.due);
                end
                if (head.illegal) begin
                    checkIllegal(head.code);
                end else begin
                    checkResult(head.data, head.rd);
                end
            end else if (expQ.size() != 0 && expQ[0].due == movingEdges) begin
                head = expQ.pop_front();
                errorCount++;
                $display("Missing output pulse at time %0t for opcode %0d, rd r%0d",
                         $time, head.code, head.rd);
            end
            movingEdges++;
        end
    end

    // Run limit grows with the work issued
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 4 * issuedCount + 50) begin
            $display("Timeout after %0d cycles, %0d outputs still outstanding",
                     cycleCount, expQ.size());
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        hold        = 1'b0;
        issue       = 1'b0;
        instrWord   = '0;
        pc          = '0;
        seed        = 32'h1a60;
        errorCount  = 0;
        checkCount  = 0;
        issuedCount = 0;
        cycleCount  = 0;
        movingEdges = 0;
        pcNext      = 16'h0100;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mirror[i] = '0;
        end
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        // Loads from r0, then directed R ops
        issueNext(iWord(ADDI, 1, 0, 7));
        issueNext(iWord(ADDI, 2, 0, 3));
        issueNext(iWord(ADDI, 3, 0, -5));      // Negative word
        issueNext(iWord(ADDI, 4, 0, 0));
        issueNext(iWord(ADDI, 5, 0, 100));
        issueNext(iWord(ADDI, 6, 0, 35));      // Shift above 31
        issueNext(iWord(ADDI, 7, 0, -1));
        issueNext(iWord(ADDI, 8, 0, 32'h3FFFF)); // Largest positive immediate
        issueNext(iWord(ADDI, 15, 0, 32));
        issueNext(rWord(ADD, 9, 1, 2));
        issueNext(rWord(SUB, 9, 2, 1));        // Wraps below zero
        issueNext(rWord(MUL, 10, 3, 5));
        issueNext(rWord(DIV, 10, 5, 1));
        issueNext(rWord(DIV, 11, 1, 4));       // Divide by zero
        issueNext(rWord(ABS, 11, 3, 0));
        issueNext(rWord(SLT, 12, 1, 2));
        issueNext(rWord(SGT, 12, 1, 2));
        issueNext(rWord(SEQ, 12, 1, 1));
        issueNext(rWord(SNEZ, 12, 4, 0));
        issueNext(rWord(SNEZ, 13, 1, 0));
        issueNext(rWord(MIN, 13, 3, 1));
        issueNext(rWord(SLL, 14, 1, 6));
        issueNext(rWord(SLL, 14, 7, 15));      // Amount 32 acts as 0
        drain();

        // Each instruction reads the previous rd
        issueNext(iWord(ADDI, 1, 0, 3));
        issueNext(rWord(ADD, 2, 1, 1));
        issueNext(rWord(MUL, 3, 2, 1));
        issueNext(rWord(SUB, 4, 3, 2));
        issueNext(iWord(SLLI, 5, 4, 4));
        issueNext(rWord(DIV, 6, 5, 4));
        issueNext(rWord(MIN, 7, 6, 5));
        issueNext(rWord(ADD, 7, 7, 7));        // Same rd twice
        issueNext(rWord(SEQ, 8, 7, 7));
        issueNext(iWord(ADDI, 8, 8, -2));
        issueNext(rWord(SUB, 9, 1, 8));        // Forward on B only
        drain();

        // I forms with negative immediates, BEQZ, JAL
        issueNext(iWord(ADDI, 1, 5, -7));
        issueNext(iWord(MULI, 2, 1, -3));
        issueNext(iWord(DIVI, 3, 5, -1));
        issueNext(iWord(DIVI, 3, 7, -1));
        issueNext(iWord(DIVI, 4, 2, 0));
        issueNext(iWord(SLLI, 4, 1, -1));      // Low 5 bits give 31
        issueNext(iWord(ADDI, 5, 0, -262144)); // Most negative immediate
        issueNext(iWord(BEQZ, 10, 0, 0));
        issueNext(iWord(BEQZ, 10, 5, 0));
        issueAt(iWord(JAL, 11, 0, 256), 16'hFFF0);
        issueAt(iWord(JAL, 12, 0, -32), 16'h0010);
        drain();

        // Illegal words leave the registers alone
        issueNext(badWord(17, 1));
        issueNext(rWord(ADD, 2, 1, 0));
        issueNext(badWord(31, 2));
        issueNext(rWord(ADD, 3, 2, 1));
        issueNext(badWord(24, 3));
        issueNext(badWord(20, 3));
        issueNext(iWord(ADDI, 4, 3, 0));
        drain();

        // Random with hold, then read every register back
        randomStream(300);
        for (int i = 0; i < `REG_COUNT; i++) begin
            issueNext(iWord(ADDI, i, i, 0));
        end
        drain();
        repeat (4) idleCycle();                // Stray pulses would show here

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hdl/aluPipe.sv
`include "coreCfg.svh"

module aluPipe
    import coreTypesPkg::*, isaPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  logic                   issue,
    input  logic [`DATA_WIDTH-1:0] instrWord,
    input  pc_t                    pc,
    output logic                   resultValid,
    output data_t                  resultData,
    output regIndex_t              resultRd,
    output logic                   illegalOp
);

    // Decode to operand read
    logic      decValid;
    opcode_e   decOp;
    regIndex_t decRd;
    regIndex_t decRs1;
    regIndex_t decRs2;
    data_t     decImm;
    pc_t       decPc;
    logic      decIllegal;

    // Operand read to execute
    logic      opValid;
    logic      opIllegal;
    opcode_e   opOp;
    regIndex_t opRd;
    data_t     opA;
    data_t     opB;
    data_t     opImm;
    pc_t       opPc;

    decodeStage decode (
        .clk        (clk),
        .reset      (reset),
        .hold       (hold),
        .issue      (issue),
        .instrWord  (instrWord),        // Viewed through the union inside
        .pc         (pc),
        .decValid   (decValid),
        .decOp      (decOp),
        .decRd      (decRd),
        .decRs1     (decRs1),
        .decRs2     (decRs2),
        .decImm     (decImm),
        .decPc      (decPc),
        .decIllegal (decIllegal)
    );

    operandStage operand (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .decValid    (decValid),
        .decOp       (decOp),
        .decRd       (decRd),
        .decRs1      (decRs1),
        .decRs2      (decRs2),
        .decImm      (decImm),
        .decPc       (decPc),
        .decIllegal  (decIllegal),
        .resultValid (resultValid),     // Writeback loop
        .resultData  (resultData),
        .resultRd    (resultRd),
        .opValid     (opValid),
        .opIllegal   (opIllegal),
        .opOp        (opOp),
        .opRd        (opRd),
        .opA         (opA),
        .opB         (opB),
        .opImm       (opImm),
        .opPc        (opPc)
    );

    aluStage execute (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .opValid     (opValid),
        .opIllegal   (opIllegal),
        .opOp        (opOp),
        .opRd        (opRd),
        .opA         (opA),
        .opB         (opB),
        .opImm       (opImm),
        .opPc        (opPc),
        .resultValid (resultValid),
        .resultData  (resultData),
        .resultRd    (resultRd),
        .illegalOp   (illegalOp)
    );

endmodule

//--- hdl/aluStage.sv
`include "coreCfg.svh"

module aluStage
    import coreTypesPkg::*, isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  logic      opValid,
    input  logic      opIllegal,
    input  opcode_e   opOp,
    input  regIndex_t opRd,
    input  data_t     opA,
    input  data_t     opB,
    input  data_t     opImm,
    input  pc_t       opPc,
    output logic      resultValid,
    output data_t     resultData,
    output regIndex_t resultRd,
    output logic      illegalOp
);

    localparam int shiftWidth = $clog2(`DATA_WIDTH);

    data_t                 srcB;
    data_t                 aluOut;
    logic [shiftWidth-1:0] shiftAmount;

    // Immediate replaces B for the I forms
    assign srcB        = isIType(opOp) ? opImm : opB;
    assign shiftAmount = srcB[shiftWidth-1:0];          // Only the low bits count

    always_comb begin
        case (opOp)
            ADD, ADDI: aluOut = opA + srcB;              // Wraps modulo 2^32
            SUB:       aluOut = opA - srcB;
            MUL, MULI: aluOut = opA * srcB;              // Low word of the product
            DIV, DIVI: aluOut = (srcB == '0) ? '1 : opA / srcB;
            ABS:       aluOut = {1'b0, opA[`DATA_WIDTH-2:0]};  // Sign bit cleared
            SLT:       aluOut = data_t'(opA < srcB);
            SGT:       aluOut = data_t'(opA > srcB);
            SEQ:       aluOut = data_t'(opA == srcB);
            SNEZ:      aluOut = data_t'(opA != '0);
            MIN:       aluOut = (opA < srcB) ? opA : srcB;
            SLL, SLLI: aluOut = opA << shiftAmount;
            // Branch condition only, no redirect here
            BEQZ:      aluOut = data_t'(opA == '0);
            JAL:       aluOut = data_t'(opPc) + opImm;   // Target, pc zero-extended
            default:   aluOut = '0;                      // Illegal codes, never written
        endcase
    end

    // Strobes, one cycle per instruction unless frozen
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            illegalOp   <= 1'b0;
        end else if (!hold) begin
            resultValid <= opValid && !opIllegal;
            illegalOp   <= opValid && opIllegal;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (!hold && opValid) begin
            resultData <= aluOut;
            resultRd   <= opRd;
        end
    end

endmodule

//--- hdl/coreTypesPkg.sv
`include "coreCfg.svh"

package coreTypesPkg;

    // Plain data word, the ALU treats it as unsigned
    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef logic [`PC_WIDTH-1:0] pc_t;               // Instruction address

    typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;  // Register number, r0 included

endpackage

//--- hdl/decodeStage.sv
module decodeStage
    import coreTypesPkg::*, isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  logic      issue,
    input  isaWord_u  instrWord,
    input  pc_t       pc,
    output logic      decValid,
    output opcode_e   decOp,
    output regIndex_t decRd,
    output regIndex_t decRs1,
    output regIndex_t decRs2,
    output data_t     decImm,
    output pc_t       decPc,
    output logic      decIllegal
);

    opcode_e   wordOp;
    logic      wordIType;
    regIndex_t wordRd;
    regIndex_t wordRs1;
    regIndex_t wordRs2;
    data_t     wordImm;

    // Opcode, rd and rs1 sit in the same bits of both layouts
    assign wordOp    = instrWord.r.opcode;
    assign wordRd    = instrWord.r.rd;
    assign wordRs1   = instrWord.r.rs1;
    assign wordIType = isIType(wordOp);

    // Second source or immediate per layout
    always_comb begin
        if (wordIType) begin
            wordRs2 = '0;                                   // No second source
            wordImm = signExtendImm(instrWord.i.imm);
        end else begin
            wordRs2 = instrWord.r.rs2;
            wordImm = '0;                                   // Immediate unused for R ops
        end
    end

    // Stage valid
    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (!hold) begin
            decValid <= issue;                              // Bubble when nothing issued
        end
    end

    // Decoded fields held until the next accepted word
    always_ff @(posedge clk) begin
        if (!hold && issue) begin
            decOp      <= wordOp;
            decRd      <= wordRd;
            decRs1     <= wordRs1;
            decRs2     <= wordRs2;
            decImm     <= wordImm;
            decPc      <= pc;
            decIllegal <= isIllegal(wordOp);                // Rides along with the word
        end
    end

endmodule

//--- hdl/isaPkg.sv
`include "coreCfg.svh"

package isaPkg;
    import coreTypesPkg::*;

    // Field sizes left over after opcode and register indices
    localparam int immWidth    = `DATA_WIDTH - `OPCODE_WIDTH - 2 * `REG_INDEX_WIDTH;
    localparam int unusedWidth = immWidth - `REG_INDEX_WIDTH;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        // Register-register
        ADD  = 0,
        SUB  = 1,
        MUL  = 2,
        DIV  = 3,
        ABS  = 4,
        SLT  = 5,
        SGT  = 6,
        SEQ  = 7,
        SNEZ = 8,
        MIN  = 9,
        SLL  = 10,
        // Register-immediate
        ADDI = 11,
        MULI = 12,
        DIVI = 13,
        SLLI = 14,
        // Control flow, value only
        BEQZ = 15,
        JAL  = 16       // Highest legal code
    } opcode_e;

    // R layout, opcode at the top
    typedef struct packed {
        opcode_e                opcode;
        regIndex_t              rd;
        regIndex_t              rs1;
        regIndex_t              rs2;
        logic [unusedWidth-1:0] unused;  // Don't care
    } rTypeFields_t;

    // I layout, immediate replaces rs2 and the unused bits
    typedef struct packed {
        opcode_e             opcode;
        regIndex_t           rd;
        regIndex_t           rs1;
        logic [immWidth-1:0] imm;        // Two's complement
    } iTypeFields_t;

    // One word, two views
    typedef union packed {
        rTypeFields_t r;
        iTypeFields_t i;
    } isaWord_u;

    // Opcodes that carry an immediate
    function automatic logic isIType(opcode_e op);
        case (op)
            ADDI, MULI, DIVI, SLLI, BEQZ, JAL: return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

    function automatic logic isIllegal(opcode_e op);
        return op > JAL;    // Codes 17 and up
    endfunction

    function automatic data_t signExtendImm(logic [immWidth-1:0] imm);
        return {{(`DATA_WIDTH - immWidth){imm[immWidth-1]}}, imm};
    endfunction

endpackage

//--- hdl/operandStage.sv
`include "coreCfg.svh"

module operandStage
    import coreTypesPkg::*, isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    // From decode
    input  logic      decValid,
    input  opcode_e   decOp,
    input  regIndex_t decRd,
    input  regIndex_t decRs1,
    input  regIndex_t decRs2,
    input  data_t     decImm,
    input  pc_t       decPc,
    input  logic      decIllegal,
    // Writeback and forward source
    input  logic      resultValid,
    input  data_t     resultData,
    input  regIndex_t resultRd,
    // To execute
    output logic      opValid,
    output logic      opIllegal,
    output opcode_e   opOp,
    output regIndex_t opRd,
    output data_t     opA,
    output data_t     opB,
    output data_t     opImm,
    output pc_t       opPc
);

    data_t     regFile [`REG_COUNT];
    regIndex_t opRs1;
    regIndex_t opRs2;
    logic      writeEn;
    logic      fwdA;
    logic      fwdB;

    // Results retire only on a moving edge
    assign writeEn = resultValid && !hold;

    // Register file, one write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeEn) begin
            regFile[resultRd] <= resultData;
        end
    end

    // Stage valid
    always_ff @(posedge clk) begin
        if (reset) begin
            opValid <= 1'b0;
        end else if (!hold) begin
            opValid <= decValid;
        end
    end

    // Fields and source indices move one stage
    always_ff @(posedge clk) begin
        if (!hold && decValid) begin
            opIllegal <= decIllegal;
            opOp      <= decOp;
            opRd      <= decRd;
            opRs1     <= decRs1;
            opRs2     <= decRs2;
            opImm     <= decImm;
            opPc      <= decPc;
        end
    end

    // Previous instruction is still on the result bus, not yet in the file
    assign fwdA = resultValid && (resultRd == opRs1);
    assign fwdB = resultValid && (resultRd == opRs2);

    // Operand read during the execute cycle
    assign opA = fwdA ? resultData : regFile[opRs1];
    assign opB = fwdB ? resultData : regFile[opRs2];   // rs2 is r0 for I ops, value ignored

endmodule

//--- include/coreCfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath word
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4     // Enough to address REG_COUNT entries

// Top field of every instruction word
`define OPCODE_WIDTH 5

// Instruction memory address, zero-extended when used as data
`define PC_WIDTH 16

`endif

//--- src.f
+incdir+include
hdl/coreTypesPkg.sv
hdl/isaPkg.sv
hdl/decodeStage.sv
hdl/operandStage.sv
hdl/aluStage.sv
hdl/aluPipe.sv
bench/aluPipeTb.sv
